// File: md_pkg.sv
// #####################################
// Multiply/divide unit package
// Operation encoding, word types and step constants
// #####################################

package md_pkg;

  // Operand and result width
  localparam int unsigned MD_WIDTH = 32;

  // Half word fed into the 17x17 multiplier
  localparam int unsigned MD_HALF = 16;

  // One quotient bit per division step
  localparam int unsigned MD_DIV_STEPS = 32;

  // RV32M operations, multiply group first
  typedef enum logic [2:0] {
    MD_MUL    = 3'd0,
    MD_MULH   = 3'd1,
    MD_MULHSU = 3'd2,
    MD_MULHU  = 3'd3,
    MD_DIV    = 3'd4,
    MD_DIVU   = 3'd5,
    MD_REM    = 3'd6,
    MD_REMU   = 3'd7
  } md_op_e;

  typedef logic [MD_WIDTH-1:0] md_word_t;

  typedef logic [MD_HALF-1:0] md_half_t;

  // Two guard bits above a word, for carries and the borrow of the subtractor
  typedef logic [MD_WIDTH+1:0] md_acc_t;

  // Bit 0 marks operand A as signed, bit 1 operand B
  typedef logic [1:0] md_sign_t;

endpackage

// File: md_job_if.sv
// #####################################
// Job interface from the issue stage to an engine
// Four-phase req/ack with the decoded operation
// #####################################

interface md_job_if;
  import md_pkg::*;

  // Request from the issue stage, fields stable while high
  logic     req;

  // Engine answer, raised once the result buffer took the result
  logic     ack;

  // Operation and its decoded signedness
  md_op_e   op;
  md_sign_t sign;

  // Latched operands
  md_word_t op_a;
  md_word_t op_b;

  modport issuer (
    output req,
    output op,
    output sign,
    output op_a,
    output op_b,
    input  ack
  );

  modport engine (
    input  req,
    input  op,
    input  sign,
    input  op_a,
    input  op_b,
    output ack
  );

endinterface

// File: md_issue.sv
// #####################################
// Issue stage
// Takes a top-level request, decodes it and hands it to one engine
// #####################################

module md_issue (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  md_pkg::md_op_e   op_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  md_job_if.issuer         mult_job,
  md_job_if.issuer         div_job
);
  import md_pkg::*;

  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_REQ,
    ISS_DONE
  } iss_state_e;

  iss_state_e state_q;
  logic       mult_sel_q;
  logic       mult_sel_d;
  logic       job_ack;
  md_sign_t   sign_d;
  md_sign_t   sign_q;
  md_op_e     op_q;
  md_word_t   op_a_q;
  md_word_t   op_b_q;

  // Multiply group goes to the MAC engine, the rest to the divider
  assign mult_sel_d = op_i inside {MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU};

  always_comb begin
    unique case (op_i)
      MD_MULH, MD_DIV, MD_REM: sign_d = 2'b11;
      MD_MULHSU:               sign_d = 2'b01;
      default:                 sign_d = 2'b00;
    endcase
  end

  assign job_ack = mult_sel_q ? mult_job.ack : div_job.ack;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ISS_IDLE;
      mult_sel_q <= 1'b0;
    end else begin
      unique case (state_q)
        ISS_IDLE: begin
          if (req_i) begin
            state_q    <= ISS_REQ;
            mult_sel_q <= mult_sel_d;
          end
        end
        ISS_REQ: begin
          if (job_ack) begin
            state_q <= ISS_DONE;
          end
        end
        // Engine ack falls only after the outside has dropped req_i
        ISS_DONE: begin
          if (!job_ack) begin
            state_q <= ISS_IDLE;
          end
        end
        default: state_q <= ISS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ISS_IDLE && req_i) begin
      op_q   <= op_i;
      sign_q <= sign_d;
      op_a_q <= op_a_i;
      op_b_q <= op_b_i;
    end
  end

  assign mult_job.req  = (state_q == ISS_REQ) & mult_sel_q;
  assign mult_job.op   = op_q;
  assign mult_job.sign = sign_q;
  assign mult_job.op_a = op_a_q;
  assign mult_job.op_b = op_b_q;

  assign div_job.req  = (state_q == ISS_REQ) & ~mult_sel_q;
  assign div_job.op   = op_q;
  assign div_job.sign = sign_q;
  assign div_job.op_a = op_a_q;
  assign div_job.op_b = op_b_q;

endmodule

// File: md_mult_engine.sv
// #####################################
// Multiply engine
// One 17x17 signed MAC stepped over 16-bit operand halves
// #####################################

module md_mult_engine (
  input  logic             clk_i,
  input  logic             rst_ni,
  md_job_if.engine         job,
  output logic             res_req_o,
  output md_pkg::md_word_t res_data_o,
  input  logic             res_ack_i
);
  import md_pkg::*;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e            state_q;
  mult_state_e            state_d;
  md_half_t               mult_op_a;
  md_half_t               mult_op_b;
  logic                   sign_a;
  logic                   sign_b;
  md_acc_t                accum;
  md_acc_t                acc_d;
  md_acc_t                acc_q;
  logic signed [MD_WIDTH+1:0] mac_res;
  md_word_t               res_word;
  md_word_t               res_data_q;
  logic                   is_mul;
  logic                   signed_mult;
  logic                   step;
  logic                   last_step;
  logic                   res_req_q;
  logic                   ack_q;

  assign is_mul      = (job.op == MD_MUL);
  assign signed_mult = (job.sign != 2'b00);

  // Sign bits extend each half to 17 bits, the accumulator is added in the same cycle
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) + $signed(accum);

  always_comb begin
    mult_op_a = job.op_a[MD_HALF-1:0];
    mult_op_b = job.op_b[MD_HALF-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    acc_d     = mac_res;
    res_word  = mac_res[MD_WIDTH-1:0];
    state_d   = state_q;
    last_step = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end
      ALBH: begin
        mult_op_b = job.op_b[MD_WIDTH-1:MD_HALF];
        sign_b    = job.sign[1] & job.op_b[MD_WIDTH-1];
        // AL*BL is unsigned, so its upper half needs no extension
        accum     = {18'b0, acc_q[MD_WIDTH-1:MD_HALF]};
        if (is_mul) begin
          acc_d = {2'b0, mac_res[MD_HALF-1:0], acc_q[MD_HALF-1:0]};
        end
        state_d = AHBL;
      end
      AHBL: begin
        mult_op_a = job.op_a[MD_WIDTH-1:MD_HALF];
        sign_a    = job.sign[0] & job.op_a[MD_WIDTH-1];
        if (is_mul) begin
          // Low word complete
          accum     = {18'b0, acc_q[MD_WIDTH-1:MD_HALF]};
          res_word  = {mac_res[MD_HALF-1:0], acc_q[MD_HALF-1:0]};
          last_step = 1'b1;
          state_d   = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end
      AHBH: begin
        mult_op_a = job.op_a[MD_WIDTH-1:MD_HALF];
        mult_op_b = job.op_b[MD_WIDTH-1:MD_HALF];
        sign_a    = job.sign[0] & job.op_a[MD_WIDTH-1];
        sign_b    = job.sign[1] & job.op_b[MD_WIDTH-1];
        // Cross products are signed unless both operands are unsigned
        accum     = {{16{signed_mult & acc_q[MD_WIDTH+1]}}, acc_q[MD_WIDTH+1:MD_HALF]};
        last_step = 1'b1;
        state_d   = ALBL;
      end
      default: state_d = ALBL;
    endcase
  end

  // Steps run only while a job is open and no result is pending
  assign step = job.req & ~ack_q & ~res_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ALBL;
      res_req_q <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      if (step) begin
        state_q <= state_d;
      end
      if (step && last_step) begin
        res_req_q <= 1'b1;
      end else if (res_req_q && res_ack_i) begin
        res_req_q <= 1'b0;
      end
      if (res_req_q && res_ack_i) begin
        ack_q <= 1'b1;
      end else if (ack_q && !job.req && !res_ack_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (step) begin
      acc_q <= acc_d;
    end
    if (step && last_step) begin
      res_data_q <= res_word;
    end
  end

  assign job.ack    = ack_q;
  assign res_req_o  = res_req_q;
  assign res_data_o = res_data_q;

endmodule

// File: md_div_engine.sv
// #####################################
// Divide engine
// Restoring long division on absolute values, sign fixed at the end
// #####################################

module md_div_engine (
  input  logic             clk_i,
  input  logic             rst_ni,
  md_job_if.engine         job,
  output logic             res_req_o,
  output md_pkg::md_word_t res_data_o,
  input  logic             res_ack_i
);
  import md_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  div_state_e state_q;
  div_state_e state_d;
  md_word_t   numer_q;
  md_word_t   numer_d;
  md_word_t   denom_q;
  md_word_t   denom_d;
  md_word_t   quot_q;
  md_word_t   quot_d;
  md_acc_t    rem_q;
  md_acc_t    rem_d;
  logic [4:0] cnt_q;
  logic [4:0] cnt_d;
  logic       ack_q;
  logic       run;
  md_acc_t    sub_a;
  md_acc_t    sub_b;
  md_acc_t    sub_res;
  logic       ge;
  md_word_t   next_rem;
  logic       sign_a;
  logic       sign_b;
  logic       b_zero;
  logic       is_div;
  logic       div_change_sign;
  logic       rem_change_sign;

  assign sign_a = job.sign[0] & job.op_a[MD_WIDTH-1];
  assign sign_b = job.sign[1] & job.op_b[MD_WIDTH-1];
  assign b_zero = (job.op_b == '0);
  assign is_div = job.op inside {MD_DIV, MD_DIVU};

  assign div_change_sign = (sign_a ^ sign_b) & ~b_zero;
  assign rem_change_sign = sign_a;

  // Single subtractor for negation and the compare steps
  assign sub_res  = sub_a - sub_b;
  assign ge       = ~sub_res[MD_WIDTH+1];
  assign next_rem = ge ? sub_res[MD_WIDTH-1:0] : rem_q[MD_WIDTH-1:0];

  always_comb begin
    state_d = state_q;
    numer_d = numer_q;
    denom_d = denom_q;
    quot_d  = quot_q;
    rem_d   = rem_q;
    cnt_d   = cnt_q;
    sub_a   = '0;
    sub_b   = {2'b0, job.op_b};

    unique case (state_q)
      IDLE: begin
        // Zero divisor skips the long division
        if (b_zero) begin
          rem_d   = is_div ? '1 : {2'b0, job.op_a};
          state_d = FINISH;
        end else begin
          state_d = ABS_A;
        end
      end
      ABS_A: begin
        sub_b   = {2'b0, job.op_a};
        numer_d = sign_a ? sub_res[MD_WIDTH-1:0] : job.op_a;
        state_d = ABS_B;
      end
      ABS_B: begin
        denom_d = sign_b ? sub_res[MD_WIDTH-1:0] : job.op_b;
        // First numerator bit enters the remainder
        rem_d   = {{(MD_WIDTH+1){1'b0}}, numer_q[MD_WIDTH-1]};
        cnt_d   = 5'(MD_DIV_STEPS - 1);
        state_d = COMP;
      end
      COMP: begin
        sub_a  = rem_q;
        sub_b  = {2'b0, denom_q};
        cnt_d  = cnt_q - 5'd1;
        quot_d = {quot_q[MD_WIDTH-2:0], ge};
        rem_d  = {1'b0, next_rem, numer_q[cnt_d]};
        if (cnt_q == 5'd1) begin
          state_d = LAST;
        end
      end
      LAST: begin
        sub_a = rem_q;
        sub_b = {2'b0, denom_q};
        // Result register now keeps only the wanted value
        if (is_div) begin
          rem_d = {2'b0, quot_q[MD_WIDTH-2:0], ge};
        end else begin
          rem_d = {2'b0, next_rem};
        end
        state_d = CHANGE_SIGN;
      end
      CHANGE_SIGN: begin
        sub_b = rem_q;
        if (is_div ? div_change_sign : rem_change_sign) begin
          rem_d = {2'b0, sub_res[MD_WIDTH-1:0]};
        end
        state_d = FINISH;
      end
      FINISH: begin
        if (res_ack_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Once started the division runs every cycle
  assign run = (state_q != IDLE) | (job.req & ~ack_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      ack_q   <= 1'b0;
    end else begin
      if (run) begin
        state_q <= state_d;
        cnt_q   <= cnt_d;
      end
      if (state_q == FINISH && res_ack_i) begin
        ack_q <= 1'b1;
      end else if (ack_q && !job.req && !res_ack_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (run) begin
      numer_q <= numer_d;
      denom_q <= denom_d;
      quot_q  <= quot_d;
      rem_q   <= rem_d;
    end
  end

  assign job.ack    = ack_q;
  assign res_req_o  = (state_q == FINISH);
  assign res_data_o = rem_q[MD_WIDTH-1:0];

endmodule

// File: md_result_buffer.sv
// #####################################
// Result buffer
// Takes an engine result and acknowledges the outside request
// #####################################

module md_result_buffer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  logic             mult_res_req_i,
  input  md_pkg::md_word_t mult_res_data_i,
  output logic             mult_res_ack_o,
  input  logic             div_res_req_i,
  input  md_pkg::md_word_t div_res_data_i,
  output logic             div_res_ack_o,
  output logic             ack_o,
  output md_pkg::md_word_t result_o
);
  import md_pkg::*;

  logic     ack_q;
  logic     div_sel_q;
  logic     capture;
  logic     src_req;
  md_word_t result_q;

  assign capture = ~ack_q & (mult_res_req_i | div_res_req_i);

  // Request of the engine being answered
  assign src_req = div_sel_q ? div_res_req_i : mult_res_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      div_sel_q <= 1'b0;
    end else if (capture) begin
      ack_q     <= 1'b1;
      div_sel_q <= ~mult_res_req_i;
    end else if (ack_q && !req_i && !src_req) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      result_q <= mult_res_req_i ? mult_res_data_i : div_res_data_i;
    end
  end

  assign mult_res_ack_o = ack_q & ~div_sel_q;
  assign div_res_ack_o  = ack_q & div_sel_q;
  assign ack_o          = ack_q;
  assign result_o       = result_q;

endmodule

// File: md_top.sv
// #####################################
// Multiply/divide unit top level
// Issue stage, two engines and result buffer
// #####################################

module md_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  md_pkg::md_op_e   op_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  output logic             ack_o,
  output md_pkg::md_word_t result_o
);
  import md_pkg::*;

  logic     mult_res_req;
  logic     mult_res_ack;
  md_word_t mult_res_data;
  logic     div_res_req;
  logic     div_res_ack;
  md_word_t div_res_data;

  md_job_if mult_job ();
  md_job_if div_job ();

  md_issue md_issue_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .op_i     (op_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .mult_job (mult_job.issuer),
    .div_job  (div_job.issuer)
  );

  md_mult_engine md_mult_engine_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .job        (mult_job.engine),
    .res_req_o  (mult_res_req),
    .res_data_o (mult_res_data),
    .res_ack_i  (mult_res_ack)
  );

  md_div_engine md_div_engine_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .job        (div_job.engine),
    .res_req_o  (div_res_req),
    .res_data_o (div_res_data),
    .res_ack_i  (div_res_ack)
  );

  md_result_buffer md_result_buffer_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .mult_res_req_i  (mult_res_req),
    .mult_res_data_i (mult_res_data),
    .mult_res_ack_o  (mult_res_ack),
    .div_res_req_i   (div_res_req),
    .div_res_data_i  (div_res_data),
    .div_res_ack_o   (div_res_ack),
    .ack_o           (ack_o),
    .result_o        (result_o)
  );

endmodule

// File: md_top_asserts.sv
// #####################################
// Handshake assertions for the multiply/divide unit
// #####################################

module md_top_asserts (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             req_i,
  input logic             ack_o,
  input md_pkg::md_word_t result_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // No acknowledge may start while the request is low
  ack_needs_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!req_i && !ack_o) |=> !ack_o)
    else begin
      $error("ack_o rose without req_i");
      fail_cnt++;
    end

  ack_result_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> (!ack_o || $stable(result_o)))
    else begin
      $error("result_o changed while ack_o was high");
      fail_cnt++;
    end

  ack_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o && req_i) |=> ack_o)
    else begin
      $error("ack_o fell while req_i was still high");
      fail_cnt++;
    end

  ack_release_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_o && !req_i) |-> ##[1:3] !ack_o)
    else begin
      $error("ack_o did not fall after req_i fell");
      fail_cnt++;
    end

endmodule

bind md_top md_top_asserts md_top_asserts_i (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (req_i),
  .ack_o    (ack_o),
  .result_o (result_o)
);

// File: tb_md_top.sv
// #####################################
// Testbench for the multiply/divide unit
// Runs file vectors through the req/ack handshake
// #####################################

module tb_md_top;
  timeunit 1ns;
  timeprecision 100ps;
  import md_pkg::*;

  localparam int MAX_VECS = 64;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  md_op_e      op_i;
  md_word_t    op_a_i;
  md_word_t    op_b_i;
  logic        ack_o;
  md_word_t    result_o;

  // Four words per vector: op, a, b, expected
  logic [31:0] vec_mem [0:MAX_VECS*4-1];
  int          num_vecs;
  int          vec_idx;
  int          cycle_limit;
  int          cycle_cnt;
  int          value_errs;
  int          ack_errs;
  int          other_errs;

  md_top md_top_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .op_i     (op_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .ack_o    (ack_o),
    .result_o (result_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_result(input string name, input md_word_t actual,
                              input md_word_t expected);
    if (actual !== expected) begin
      value_errs++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_ack(input logic actual, input logic expected);
    if (actual !== expected) begin
      ack_errs++;
      $display("Mismatch at %0t: ack_o is %b, expected %b", $time, actual, expected);
    end
  endtask

  task automatic end_run();
    int assert_errs;
    assert_errs = md_top_i.md_top_asserts_i.fail_cnt;
    $display("Errors: value %0d, handshake %0d, assertion %0d, other %0d",
             value_errs, ack_errs, assert_errs, other_errs);
    if (value_errs + ack_errs + assert_errs + other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // One full four-phase transfer with random hold and idle times
  task automatic run_vector(input int idx);
    md_word_t expected;
    int       hold;
    int       gap;
    expected = vec_mem[idx*4+3];
    hold     = $urandom_range(3, 0);
    gap      = $urandom_range(3, 0);
    op_i   = md_op_e'(vec_mem[idx*4][2:0]);
    op_a_i = vec_mem[idx*4+1];
    op_b_i = vec_mem[idx*4+2];
    req_i  = 1'b1;
    @(negedge clk_i);
    while (ack_o !== 1'b1) begin
      @(negedge clk_i);
    end
    check_result("result_o", result_o, expected);
    // Back-pressure, the answer must hold
    repeat (hold) begin
      @(negedge clk_i);
      check_ack(ack_o, 1'b1);
      check_result("result_o", result_o, expected);
    end
    req_i  = 1'b0;
    op_a_i = $urandom();
    op_b_i = $urandom();
    @(negedge clk_i);
    while (ack_o !== 1'b0) begin
      @(negedge clk_i);
    end
    // Idle gap before the next request
    repeat (gap) begin
      @(negedge clk_i);
      check_ack(ack_o, 1'b0);
    end
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    op_i       = MD_MUL;
    op_a_i     = '0;
    op_b_i     = '0;
    value_errs = 0;
    ack_errs   = 0;
    other_errs = 0;
    void'($urandom(37));
    $readmemh("md_tests.txt", vec_mem);
    num_vecs = 0;
    while (num_vecs < MAX_VECS && !$isunknown(vec_mem[num_vecs*4])) begin
      num_vecs++;
    end
    if (num_vecs == 0) begin
      other_errs++;
      $display("No test vectors could be read from md_tests.txt");
    end
    // Worst case is a division with full hold and gap
    cycle_limit = num_vecs * 45 + 100;
    repeat (4) begin
      @(negedge clk_i);
      check_ack(ack_o, 1'b0);
    end
    rst_ni = 1'b1;
    // Idle after reset, no acknowledge expected
    repeat (3) begin
      @(negedge clk_i);
      check_ack(ack_o, 1'b0);
    end
    for (vec_idx = 0; vec_idx < num_vecs; vec_idx++) begin
      run_vector(vec_idx);
    end
    end_run();
  end

  // Watchdog
  initial begin
    @(posedge rst_ni);
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    other_errs++;
    $display("Timeout: vectors not finished after %0d cycles", cycle_limit);
    end_run();
  end

endmodule

// File: md_tests.txt
// Columns in hex: op (0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU) a b expected
// One operation per line, results follow the RV32M rules
0 00000007 00000006 0000002A
0 FFFFFFFF FFFFFFFF 00000001
0 12345678 9ABCDEF0 242D2080
0 FFFFFFFE 00000003 FFFFFFFA
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 80000000 80000000 40000000
1 FFFFFFFF FFFFFFFF 00000000
1 80000000 7FFFFFFF C0000000
1 FFFFFFFE 00000003 FFFFFFFF
1 12345678 9ABCDEF0 F8CC93D6
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 00000002 FFFFFFFF 00000001
2 80000000 80000000 C0000000
2 9ABCDEF0 12345678 F8CC93D6
3 FFFFFFFF FFFFFFFF FFFFFFFE
3 12345678 9ABCDEF0 0B00EA4E
4 00000014 00000006 00000003
4 FFFFFFEC 00000006 FFFFFFFD
4 00000014 FFFFFFFA FFFFFFFD
4 FFFFFFEC FFFFFFFA 00000003
4 80000000 FFFFFFFF 80000000
5 FFFFFFEC 00000006 2AAAAAA7
5 12345678 00000010 01234567
5 00000005 00000007 00000000
6 00000014 00000006 00000002
6 FFFFFFEC 00000006 FFFFFFFE
6 00000014 FFFFFFFA 00000002
6 FFFFFFEC FFFFFFFA FFFFFFFE
6 80000000 FFFFFFFF 00000000
7 FFFFFFEC 00000006 00000002
7 12345678 00000010 00000008
7 00000005 00000007 00000005
4 00000123 00000000 FFFFFFFF
5 00000123 00000000 FFFFFFFF
6 FFFFFF9C 00000000 FFFFFF9C
7 00000123 00000000 00000123

// File: flist.f
md_pkg.sv
md_job_if.sv
md_issue.sv
md_mult_engine.sv
md_div_engine.sv
md_result_buffer.sv
md_top.sv
md_top_asserts.sv
tb_md_top.sv
